//--- Bender.yml
package:
  name: img_grad

sources:
  - img_grad_pkg.sv
  - scan_ctrl.sv
  - line_buffer.sv
  - grad_calc.sv
  - img_grad_top.sv
  - target: test
    files:
      - tb_mem_models.sv
      - tb_img_grad.sv

//--- compile.f
img_grad_pkg.sv
scan_ctrl.sv
line_buffer.sv
grad_calc.sv
img_grad_top.sv
tb_mem_models.sv
tb_img_grad.sv

//--- grad_calc.sv
`timescale 1ns/1ps

module grad_calc (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            emit,
    input  logic                            edge_col,
    input  logic [img_grad_pkg::pix_w-1:0]  img_di,
    input  logic [img_grad_pkg::pix_w-1:0]  tap_up,
    input  logic [img_grad_pkg::pix_w-1:0]  tap_up_right,
    output logic                            grad_wr,
    output logic [img_grad_pkg::addr_w-1:0] grad_addr,
    output logic [img_grad_pkg::grad_w-1:0] grad_do
);
    import img_grad_pkg::*;

    // pixels widened with zeros before the subtraction
    logic [diff_w-1:0] up_x;
    logic [diff_w-1:0] right_x;
    logic [diff_w-1:0] down_x;

    // two's complement differences
    logic [diff_w-1:0] gx;
    logic [diff_w-1:0] gy;

    assign up_x    = diff_w'(tap_up);
    assign right_x = diff_w'(tap_up_right);
    assign down_x  = diff_w'(img_di);

    always_comb begin
        // no right neighbour on the last column
        if (edge_col) begin
            gx = '0;
        end else begin
            gx = right_x - up_x;
        end
        gy = down_x - up_x;
    end

    // gradient word, loaded only when a pixel produces output
    always_ff @(posedge clk) begin
        if (emit) begin
            grad_do <= {gx, gy};
        end
    end

    // write strobe one cycle behind emit
    always_ff @(posedge clk) begin
        if (reset) begin
            grad_wr <= 1'b0;
        end else begin
            grad_wr <= emit;
        end
    end

    // address shown with the strobe, stepped once the write is taken
    always_ff @(posedge clk) begin
        if (reset) begin
            grad_addr <= '0;
        end else if (grad_wr) begin
            grad_addr <= grad_addr + 1'b1;
        end
    end

endmodule

//--- img_grad_pkg.sv
package img_grad_pkg;

    // width of both memory addresses, up to 65536 pixels per frame
    localparam int addr_w = 16;

    // grey pixel
    localparam int pix_w = 8;

    // one signed difference, 9 bits needed, 10 kept for the packed layout
    localparam int diff_w = 10;

    // packed word, gx in the upper half and gy in the lower half
    localparam int grad_w = 2 * diff_w;

    // scan controller states
    typedef enum logic [1:0] {
        st_idle,
        st_scan,
        st_flush,
        st_done
    } scan_state_t;

endpackage

//--- img_grad_top.sv
`timescale 1ns/1ps

module img_grad_top #(
    parameter int WIDTH  = 256,
    parameter int HEIGHT = 256
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [img_grad_pkg::pix_w-1:0]  img_di,
    output logic                            done,
    output logic                            img_rd,
    output logic [img_grad_pkg::addr_w-1:0] img_addr,
    output logic                            grad_wr,
    output logic [img_grad_pkg::addr_w-1:0] grad_addr,
    output logic [img_grad_pkg::grad_w-1:0] grad_do
);
    import img_grad_pkg::*;

    // strobes for the pixel currently on img_di
    logic pix_valid;
    logic emit;
    logic edge_col;

    // pixels one row back
    logic [pix_w-1:0] tap_up;
    logic [pix_w-1:0] tap_up_right;

    scan_ctrl #(
        .WIDTH  (WIDTH),
        .HEIGHT (HEIGHT)
    ) scan_ctrl_i (
        .clk       (clk),
        .reset     (reset),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .pix_valid (pix_valid),
        .emit      (emit),
        .edge_col  (edge_col),
        .done      (done)
    );

    line_buffer #(
        .WIDTH (WIDTH)
    ) line_buffer_i (
        .clk          (clk),
        .reset        (reset),
        .pix_valid    (pix_valid),
        .img_di       (img_di),
        .tap_up       (tap_up),
        .tap_up_right (tap_up_right)
    );

    // img_di is the lower neighbour of the pixel on tap_up
    grad_calc grad_calc_i (
        .clk          (clk),
        .reset        (reset),
        .emit         (emit),
        .edge_col     (edge_col),
        .img_di       (img_di),
        .tap_up       (tap_up),
        .tap_up_right (tap_up_right),
        .grad_wr      (grad_wr),
        .grad_addr    (grad_addr),
        .grad_do      (grad_do)
    );

endmodule

//--- line_buffer.sv
`timescale 1ns/1ps

module line_buffer #(
    parameter int WIDTH = 256
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           pix_valid,
    input  logic [img_grad_pkg::pix_w-1:0] img_di,
    output logic [img_grad_pkg::pix_w-1:0] tap_up,
    output logic [img_grad_pkg::pix_w-1:0] tap_up_right
);
    import img_grad_pkg::*;

    localparam int ptr_w = $clog2(WIDTH);

    localparam logic [ptr_w-1:0] last_ptr = ptr_w'(WIDTH - 1);

    // one row of pixels, oldest entry under the pointer
    logic [pix_w-1:0] row_mem [WIDTH];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] wr_ptr_nxt;

    // pointer wraps at WIDTH, which need not be a power of two
    always_comb begin
        if (wr_ptr == last_ptr) begin
            wr_ptr_nxt = '0;
        end else begin
            wr_ptr_nxt = wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (pix_valid) begin
            wr_ptr <= wr_ptr_nxt;
        end
    end

    // arriving pixel replaces the one a full row back
    always_ff @(posedge clk) begin
        if (pix_valid) begin
            row_mem[wr_ptr] <= img_di;
        end
    end

    // taps read before the overwrite
    // under the pointer is pixel j-WIDTH, next entry is j-WIDTH+1
    assign tap_up       = row_mem[wr_ptr];
    assign tap_up_right = row_mem[wr_ptr_nxt];

endmodule

//--- scan_ctrl.sv
`timescale 1ns/1ps

module scan_ctrl #(
    parameter int WIDTH  = 256,
    parameter int HEIGHT = 256
) (
    input  logic                            clk,
    input  logic                            reset,
    output logic                            img_rd,
    output logic [img_grad_pkg::addr_w-1:0] img_addr,
    output logic                            pix_valid,
    output logic                            emit,
    output logic                            edge_col,
    output logic                            done
);
    import img_grad_pkg::*;

    localparam int col_w = $clog2(WIDTH);

    // last pixel address of the frame
    localparam logic [addr_w-1:0] last_addr = addr_w'(WIDTH * HEIGHT - 1);

    // last column index of a row
    localparam logic [col_w-1:0] last_col = col_w'(WIDTH - 1);

    scan_state_t state;
    scan_state_t state_nxt;

    logic [addr_w-1:0] addr;
    logic [col_w-1:0]  col;
    logic              row_reached;
    logic              flush_cnt;
    logic              col_end;

    assign col_end = (col == last_col);

    // next state
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                // one idle cycle after reset, then the pass starts
                state_nxt = st_scan;
            end
            st_scan: begin
                if (addr == last_addr) begin
                    state_nxt = st_flush;
                end
            end
            st_flush: begin
                // two cycles let the last pixel through the pipeline
                if (flush_cnt) begin
                    state_nxt = st_done;
                end
            end
            st_done: begin
                state_nxt = st_done;
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    // state and read-side counters
    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= st_idle;
            addr        <= '0;
            col         <= '0;
            row_reached <= 1'b0;
            flush_cnt   <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == st_scan) begin
                addr <= addr + 1'b1;
                if (col_end) begin
                    col <= '0;
                    // first row done, every later read has a pixel above
                    row_reached <= 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end
            if (state == st_flush) begin
                flush_cnt <= 1'b1;
            end else begin
                flush_cnt <= 1'b0;
            end
        end
    end

    // strobes for the pixel that arrives one clock after its read
    always_ff @(posedge clk) begin
        if (reset) begin
            pix_valid <= 1'b0;
            emit      <= 1'b0;
            edge_col  <= 1'b0;
        end else begin
            pix_valid <= img_rd;
            emit      <= img_rd & row_reached;
            edge_col  <= img_rd & row_reached & col_end;
        end
    end

    assign img_rd   = (state == st_scan);
    assign img_addr = addr;
    assign done     = (state == st_done);

endmodule

//--- tb_img_grad.sv
`timescale 1ns/1ps

module tb_img_grad;
    import img_grad_pkg::*;

    localparam int img_w       = 16;
    localparam int img_h       = 8;
    localparam int n_pix       = img_w * img_h;
    localparam int n_out       = img_w * (img_h - 1);
    localparam int cycle_limit = 16 + n_pix + 50;

    logic              clk;
    logic              reset;
    logic [pix_w-1:0]  img_di;
    logic              done;
    logic              img_rd;
    logic [addr_w-1:0] img_addr;
    logic              grad_wr;
    logic [addr_w-1:0] grad_addr;
    logic [grad_w-1:0] grad_do;
    int                wr_cnt;
    int                dup_cnt;

    // copy of the image for the expected values
    logic [pix_w-1:0] img [n_pix];
    logic [31:0]      lfsr;

    int err_value    = 0;
    int err_count    = 0;
    int err_protocol = 0;

    // monitor state cleared while reset is high
    int   cyc;
    int   rd_w_cycle;
    int   exp_addr;
    int   rd_cnt;
    logic seen_rd;
    logic rd_ended;
    logic grad_wr_q;
    logic done_q;
    logic wr_ended;

    int   run_cycles = 0;
    logic reset_q    = 1'b0;

    img_grad_top #(
        .WIDTH  (img_w),
        .HEIGHT (img_h)
    ) img_grad_top_i (
        .clk       (clk),
        .reset     (reset),
        .img_di    (img_di),
        .done      (done),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do)
    );

    tb_img_mem img_mem_i (
        .clk      (clk),
        .img_rd   (img_rd),
        .img_addr (img_addr),
        .img_di   (img_di)
    );

    tb_grad_mem grad_mem_i (
        .clk       (clk),
        .reset     (reset),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .wr_cnt    (wr_cnt),
        .dup_cnt   (dup_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // galois form with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // gx is right minus pixel and gy is below minus pixel, wrapped to 10 bits
    function automatic logic [grad_w-1:0] grad_ref(input int i);
        int                gx_int;
        int                gy_int;
        logic [diff_w-1:0] gx;
        logic [diff_w-1:0] gy;
        gy_int = int'(img[i + img_w]) - int'(img[i]);
        if ((i % img_w) == img_w - 1) begin
            gx_int = 0;
        end else begin
            gx_int = int'(img[i + 1]) - int'(img[i]);
        end
        gx = gx_int[diff_w-1:0];
        gy = gy_int[diff_w-1:0];
        return {gx, gy};
    endfunction

    task automatic fill_image(input logic random);
        logic [pix_w-1:0] v;
        int               row;
        int               col;
        for (int a = 0; a < n_pix; a++) begin
            row = a / img_w;
            col = a % img_w;
            v = 8'h5a;
            if (random) begin
                for (int b = 0; b < pix_w; b++) begin
                    v = {v[pix_w-2:0], lfsr[0]};
                    lfsr = lfsr_next(lfsr);
                end
                // big step from the end of even rows into the next row
                if (col == img_w - 1 && row % 2 == 0) begin
                    v = 8'h00;
                end else if (col == 0 && row % 2 == 1) begin
                    v = 8'hff;
                end
            end
            img[a] = v;
            img_mem_i.pix_mem[a] = v;
        end
    endtask

    task automatic run_pass(input logic random);
        @(negedge clk);
        reset = 1'b1;
        fill_image(random);
        repeat (16) @(negedge clk);
        reset = 1'b0;
        while (!done) begin
            @(negedge clk);
        end
        repeat (20) @(negedge clk);
        if (wr_cnt != n_out) begin
            err_count++;
            $display("wrote %0d gradient words, expected %0d", wr_cnt, n_out);
        end
        if (dup_cnt != 0) begin
            err_count++;
            $display("%0d gradient writes hit an address written before", dup_cnt);
        end
        for (int a = 0; a < n_out; a++) begin
            if (!grad_mem_i.written[a]) begin
                err_count++;
                $display("gradient address %h was never written", a);
            end else if (grad_mem_i.grad_store[a] !== grad_ref(a)) begin
                err_value++;
                $display("mismatch grad_store addr %h expected %h actual %h",
                         a, grad_ref(a), grad_mem_i.grad_store[a]);
            end
        end
    endtask

    // compare and protocol checks
    always @(posedge clk) begin
        if (reset) begin
            cyc        = 0;
            rd_w_cycle = -10;
            exp_addr   = 0;
            rd_cnt     = 0;
            seen_rd    = 1'b0;
            rd_ended   = 1'b0;
            grad_wr_q  = 1'b0;
            done_q     = 1'b0;
            wr_ended   = 1'b0;
        end else begin
            cyc = cyc + 1;
            if (!seen_rd) begin
                if (grad_wr || done) begin
                    err_protocol++;
                    $display("grad_wr or done high before the first image read");
                end
                seen_rd = img_rd;
            end
            // reads run from address 0 without a gap
            if (img_rd) begin
                if (rd_ended) begin
                    err_protocol++;
                    $display("image reads do not form one unbroken run");
                end
                if (int'(img_addr) != rd_cnt) begin
                    err_value++;
                    $display("mismatch img_addr expected %h actual %h", rd_cnt, img_addr);
                end
                rd_cnt = rd_cnt + 1;
            end else if (rd_cnt != 0) begin
                rd_ended = 1'b1;
            end
            if (img_rd && img_addr == addr_w'(img_w)) begin
                rd_w_cycle = cyc;
            end
            if (grad_wr) begin
                if (exp_addr == 0 && cyc != rd_w_cycle + 2) begin
                    err_protocol++;
                    $display("first gradient write at cycle %0d, expected %0d",
                             cyc, rd_w_cycle + 2);
                end
                if (wr_ended) begin
                    err_protocol++;
                    $display("gradient writes do not form one unbroken run");
                end
                if (int'(grad_addr) != exp_addr) begin
                    err_value++;
                    $display("mismatch grad_addr expected %h actual %h", exp_addr, grad_addr);
                end
                if (int'(grad_addr) >= n_out) begin
                    err_count++;
                    $display("gradient write to address %h beyond the output range", grad_addr);
                end else begin
                    if (grad_do !== grad_ref(int'(grad_addr))) begin
                        err_value++;
                        $display("mismatch grad_do addr %h expected %h actual %h",
                                 grad_addr, grad_ref(int'(grad_addr)), grad_do);
                    end
                    if ((int'(grad_addr) % img_w) == img_w - 1 &&
                        grad_do[grad_w-1:diff_w] !== '0) begin
                        err_value++;
                        $display("mismatch grad_do gx last column addr %h expected %h actual %h",
                                 grad_addr, 10'h000, grad_do[grad_w-1:diff_w]);
                    end
                end
                exp_addr = exp_addr + 1;
            end else if (grad_wr_q) begin
                wr_ended = 1'b1;
                if (!done) begin
                    err_protocol++;
                    $display("done not high in the cycle after the last gradient write");
                end
            end
            if (done && !done_q && !grad_wr_q) begin
                err_protocol++;
                $display("done rose without a gradient write in the cycle before");
            end
            if (done && !done_q && rd_cnt != n_pix) begin
                err_count++;
                $display("%0d image reads before done, expected %0d", rd_cnt, n_pix);
            end
            if (done_q && !done) begin
                err_protocol++;
                $display("done dropped before reset");
            end
            if (done && (grad_wr || img_rd)) begin
                err_protocol++;
                $display("image read or gradient write while done is high");
            end
            grad_wr_q = grad_wr;
            done_q    = done;
        end
    end

    // cycle limit per pass counted from the start of reset
    always @(posedge clk) begin
        if (reset && !reset_q) begin
            run_cycles <= 0;
        end else begin
            run_cycles <= run_cycles + 1;
        end
        reset_q <= reset;
        if (run_cycles >= cycle_limit) begin
            if (!done) begin
                $display("timeout: done never rose within %0d cycles", cycle_limit);
            end else begin
                $display("timeout: pass did not finish within %0d cycles", cycle_limit);
            end
            $display("errors: value %0d, count %0d, protocol %0d",
                     err_value, err_count, err_protocol);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        lfsr  = 32'hfe96;
        // random image first and a flat one after it
        run_pass(1'b1);
        run_pass(1'b0);
        $display("errors: value %0d, count %0d, protocol %0d",
                 err_value, err_count, err_protocol);
        if (err_value + err_count + err_protocol == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- tb_mem_models.sv
`timescale 1ns/1ps

module tb_img_mem (
    input  logic                            clk,
    input  logic                            img_rd,
    input  logic [img_grad_pkg::addr_w-1:0] img_addr,
    output logic [img_grad_pkg::pix_w-1:0]  img_di
);
    import img_grad_pkg::*;

    // loaded by the testbench while reset is high
    logic [pix_w-1:0] pix_mem [2**addr_w];

    logic              rd_q;
    logic [addr_w-1:0] addr_q;

    initial begin
        img_di = '0;
        rd_q   = 1'b0;
        addr_q = '0;
    end

    // read taken on the rising edge
    always @(posedge clk) begin
        rd_q   <= img_rd;
        addr_q <= img_addr;
    end

    // data appears on the falling edge of the following cycle
    always @(negedge clk) begin
        if (rd_q) begin
            img_di <= pix_mem[addr_q];
        end
    end

endmodule

module tb_grad_mem (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            grad_wr,
    input  logic [img_grad_pkg::addr_w-1:0] grad_addr,
    input  logic [img_grad_pkg::grad_w-1:0] grad_do,
    output int                              wr_cnt,
    output int                              dup_cnt
);
    import img_grad_pkg::*;

    logic [grad_w-1:0] grad_store [2**addr_w];
    logic              written [2**addr_w];

    always @(posedge clk) begin
        if (reset) begin
            wr_cnt  <= 0;
            dup_cnt <= 0;
            for (int a = 0; a < 2**addr_w; a++) begin
                written[a] <= 1'b0;
            end
        end else if (grad_wr) begin
            wr_cnt <= wr_cnt + 1;
            // same address twice in one pass
            if (written[grad_addr]) begin
                dup_cnt <= dup_cnt + 1;
            end
            written[grad_addr]    <= 1'b1;
            grad_store[grad_addr] <= grad_do;
        end
    end

endmodule
